/* sim/cache_test_trace.txt */
# kind 0 = stall segment: 0 <cycles> <mode>, mode 0 none, 1 held high, 2 random
# kind 1 = final counts:  1 <hit_count> <miss_count>
0 2000 0
0 1500 2
0 300 1
0 2000 2
0 500 0
0 3000 2
1 862 138

/* vlog.f */
+incdir+source
source/cache_addr_pkg.sv
source/cache_ctrl_pkg.sv
source/req_gen.sv
source/read_cache.sv
source/pattern_mem.sv
source/resp_check.sv
source/cache_test_top.sv
sim/cache_test_assert.sv
sim/cache_test_monitor.sv
sim/cache_test_tb.sv

/* Makefile */
VERILATOR := verilator
FLAGS     := --binary --assert
LINTFLAGS := --lint-only -Wall
TOP       := cache_test_tb
RTL_TOP   := cache_test_top
FILELIST  := vlog.f
OBJDIR    := obj_dir
PASS_MSG  := all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

/* sim/cache_test_tb.sv */
// testbench top: clock, reset, trace-driven memory stalls,
// watchdog and closing report
`timescale 1ns/100ps
`include "cache_macros.svh"

module cache_test_tb
  import cache_addr_pkg::*, cache_ctrl_pkg::*;
();

  // generous cycle bound for one request including its fill
  localparam int FILL_BOUND = int'(`DISTANCE) + 1 + 4 * `MEM_LATENCY + 4;

  logic         clk;
  logic         rst;
  logic         mem_stall;
  logic         req_valid;
  byte_addr_t   req_addr;
  logic         resp_valid;
  byte_t        resp_data;
  event_count_t hit_count;
  event_count_t miss_count;
  logic         test_ended;
  logic         test_error;

  int          seg_cycles[$];
  int          seg_mode[$];
  int          exp_hits;
  int          exp_misses;
  int          tb_errors = 0;
  int          mon_errors;
  test_count_t resp_count;
  int          limit_cycles = 0;
  logic [31:0] rng;

  cache_test_top dut_i (
    .clk        (clk),
    .rst        (rst),
    .mem_stall  (mem_stall),
    .req_valid  (req_valid),
    .req_addr   (req_addr),
    .resp_valid (resp_valid),
    .resp_data  (resp_data),
    .hit_count  (hit_count),
    .miss_count (miss_count),
    .test_ended (test_ended),
    .test_error (test_error)
  );

  cache_test_monitor monitor_i (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .ready      (dut_i.ready),
    .req_addr   (req_addr),
    .resp_valid (resp_valid),
    .resp_data  (resp_data),
    .hit_count  (hit_count),
    .miss_count (miss_count),
    .err_count  (mon_errors),
    .resp_count (resp_count)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] xorshift(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // kind 0 lines are stall segments, kind 1 the final counts
  task automatic load_trace();
    int    fd;
    int    n;
    int    kind;
    int    a;
    int    b;
    logic  have_counts;
    string line;
    have_counts = 1'b0;
    fd = $fopen("sim/cache_test_trace.txt", "r");
    if (fd == 0) begin
      $display("could not open the trace file sim/cache_test_trace.txt");
      tb_errors = tb_errors + 1;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0 && line.getc(0) != "#" && $sscanf(line, "%d %d %d", kind, a, b) == 3) begin
        if (kind == 0) begin
          seg_cycles.push_back(a);
          seg_mode.push_back(b);
        end else begin
          exp_hits = a;
          exp_misses = b;
          have_counts = 1'b1;
        end
      end
    end
    $fclose(fd);
    if (!have_counts) begin
      $display("the trace file has no line with the final counts");
      tb_errors = tb_errors + 1;
    end
  endtask

  // ------------------------------
  // reset and stall stimulus
  // ------------------------------

  initial begin
    int total;
    clk = 1'b0;
    rst = 1'b1;
    mem_stall = 1'b0;
    rng = 32'h9a15;
    exp_hits = 0;
    exp_misses = 0;
    load_trace();
    total = 0;
    foreach (seg_cycles[i]) begin
      total = total + seg_cycles[i];
    end
    limit_cycles = total + int'(`HOLDOFF) + int'(`NUM_TESTS) * FILL_BOUND;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    foreach (seg_cycles[i]) begin
      repeat (seg_cycles[i]) begin
        @(posedge clk);
        rng = xorshift(rng);
        case (seg_mode[i])
          1: mem_stall <= 1'b1;
          2: mem_stall <= rng[0];
          default: mem_stall <= 1'b0;
        endcase
      end
    end
    @(posedge clk);
    mem_stall <= 1'b0;
  end

  // ------------------------------
  // watchdog and closing report
  // ------------------------------

  initial begin
    wait (limit_cycles != 0);
    repeat (limit_cycles) @(posedge clk);
    $display("timeout, test_ended did not rise within %0d cycles", limit_cycles);
    $display("errors: monitor %0d, testbench %0d", mon_errors, tb_errors + 1);
    $display("tests failed");
    $finish;
  end

  initial begin
    @(negedge clk);
    while (test_ended !== 1'b1) begin
      @(negedge clk);
    end
    if (test_error !== 1'b0) begin
      $display("the response checker raised test_error");
      tb_errors = tb_errors + 1;
    end
    if (resp_count != `NUM_TESTS) begin
      $display("test_ended rose after %0d responses instead of %0d", resp_count, `NUM_TESTS);
      tb_errors = tb_errors + 1;
    end
    if (int'(hit_count) != exp_hits || int'(miss_count) != exp_misses) begin
      $display("Mismatch at %0t: final hits/misses %0d/%0d, trace expects %0d/%0d",
               $time, hit_count, miss_count, exp_hits, exp_misses);
      tb_errors = tb_errors + 1;
    end
    $display("errors: monitor %0d, testbench %0d", mon_errors, tb_errors);
    if (mon_errors == 0 && tb_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* sim/cache_test_monitor.sv */
// DUT port monitor for the cache subsystem
// address stream model, two-way LRU cache model, byte and count compare
`timescale 1ns/100ps
`include "cache_macros.svh"

module cache_test_monitor
  import cache_addr_pkg::*, cache_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         req_valid,
  input  logic         ready,
  input  byte_addr_t   req_addr,
  input  logic         resp_valid,
  input  byte_t        resp_data,
  input  event_count_t hit_count,
  input  event_count_t miss_count,
  output int           err_count,
  output test_count_t  resp_count
);

  // reference cache
  cache_tag_t             ref_tag0 [`CACHE_SETS];
  cache_tag_t             ref_tag1 [`CACHE_SETS];
  logic [`CACHE_SETS-1:0] ref_val0;
  logic [`CACHE_SETS-1:0] ref_val1;
  logic [`CACHE_SETS-1:0] ref_lru;
  event_count_t           ref_hits;
  event_count_t           ref_misses;

  // address stream and timing state
  byte_addr_t  ref_addr;
  test_count_t req_num;
  byte_addr_t  last_addr;
  logic        in_flight;
  logic        hit_due;
  logic        ready_dropped;
  logic        first_seen;
  int          cycle;
  int          last_take;

  // pattern byte of a byte address, offset 0 is the top byte
  function automatic byte_t pattern_byte(byte_addr_t a);
    word_addr_t w;
    word_t      p;
    w = a[15:2];
    p = {~w[1:0], w[5:2], 2'b00, ~w[9:6], w[13:10],
         w[9:6], 2'b11, ~w[13:10], w[1:0], ~w[5:2]};
    return byte_t'(p >> (8 * (3 - int'(a[1:0]))));
  endfunction

  // address of request number num, given the one before it
  function automatic byte_addr_t stream_addr(byte_addr_t prev, test_count_t num);
    case (num)
      20'h00040, 20'h00080, 20'h000C0, 20'h00200: return 16'h0000;
      20'h00100, 20'h00140, 20'h00180, 20'h001C0: return 16'h8000;
      default: return prev + 16'd1;
    endcase
  endfunction

  task automatic report_mismatch(input string msg);
    $display("Mismatch at %0t: %s", $time, msg);
    err_count = err_count + 1;
  endtask

  task automatic report_failure(input string msg);
    $display("at %0t %s", $time, msg);
    err_count = err_count + 1;
  endtask

  // ------------------------------
  // reference models
  // ------------------------------

  task automatic update_cache(input byte_addr_t a, output logic hit);
    set_index_t i;
    cache_tag_t t;
    i = a[7:2];
    t = a[15:8];
    hit = 1'b1;
    if (ref_val0[i] && ref_tag0[i] == t) begin
      ref_lru[i] = 1'b1;
    end else if (ref_val1[i] && ref_tag1[i] == t) begin
      ref_lru[i] = 1'b0;
    end else begin
      hit = 1'b0;
      // the lru way is replaced and the other way becomes lru
      if (ref_lru[i]) begin
        ref_val1[i] = 1'b1;
        ref_tag1[i] = t;
      end else begin
        ref_val0[i] = 1'b1;
        ref_tag0[i] = t;
      end
      ref_lru[i] = ~ref_lru[i];
    end
    if (hit) begin
      ref_hits = ref_hits + 16'd1;
    end else begin
      ref_misses = ref_misses + 16'd1;
    end
  endtask

  task automatic track_request();
    byte_addr_t want;
    logic       hit;
    want = stream_addr(ref_addr, req_num);
    if (req_addr !== want) begin
      report_mismatch($sformatf("request %0d at address %h, expected %h", req_num, req_addr, want));
    end
    // spacing is fixed only while ready stayed high
    if (first_seen && !ready_dropped && (cycle - last_take) != int'(`DISTANCE) + 1) begin
      report_mismatch($sformatf("requests %0d cycles apart, expected %0d",
                                cycle - last_take, int'(`DISTANCE) + 1));
    end
    update_cache(req_addr, hit);
    hit_due = hit;
    ref_addr = want;
    last_addr = req_addr;
    req_num = req_num + 20'd1;
    in_flight = 1'b1;
    first_seen = 1'b1;
    last_take = cycle;
    ready_dropped = 1'b0;
  endtask

  task automatic check_response();
    byte_t want;
    want = pattern_byte(last_addr);
    if (!in_flight) begin
      report_failure("resp_valid came with no request in flight");
    end else if (resp_data !== want) begin
      report_mismatch($sformatf("address %h returned %h, expected %h", last_addr, resp_data, want));
    end
    if (hit_count !== ref_hits || miss_count !== ref_misses) begin
      report_mismatch($sformatf("hits/misses %0d/%0d, model %0d/%0d",
                                hit_count, miss_count, ref_hits, ref_misses));
    end
    in_flight = 1'b0;
    resp_count = resp_count + 20'd1;
  endtask

  // ------------------------------
  // sampling
  // ------------------------------

  always @(posedge clk) begin
    if (rst) begin
      ref_val0 = '0;
      ref_val1 = '0;
      ref_lru = '0;
      ref_hits = '0;
      ref_misses = '0;
      ref_addr = 16'hFFFF;
      req_num = '0;
      in_flight = 1'b0;
      hit_due = 1'b0;
      ready_dropped = 1'b0;
      first_seen = 1'b0;
      cycle = 0;
      last_take = 0;
      err_count = 0;
      resp_count = '0;
    end else begin
      cycle = cycle + 1;
      if (!ready) begin
        ready_dropped = 1'b1;
      end
      if (hit_due && !resp_valid) begin
        report_failure("a hit did not answer in the cycle after its request");
      end
      hit_due = 1'b0;
      if (resp_valid) begin
        check_response();
      end
      if (req_valid && ready) begin
        track_request();
      end
    end
  end

endmodule

/* sim/cache_test_assert.sv */
// concurrent assertions on the read_cache handshakes
// bound into every read_cache instance
`timescale 1ns/100ps

module cache_test_assert (
  input logic clk,
  input logic rst,
  input logic ready,
  input logic resp_valid,
  input logic mem_rd
);

  // an answer is a single-cycle strobe
  resp_single: assert property (@(posedge clk) disable iff (rst) resp_valid |=> !resp_valid)
    else $error("resp_valid stayed high for two cycles");

  // memory reads only start a miss
  rd_in_miss: assert property (@(posedge clk) disable iff (rst) mem_rd |-> !ready)
    else $error("mem_rd issued while ready is high");

  // ready comes back only together with the answer
  ready_held: assert property (@(posedge clk) disable iff (rst)
      !ready |=> (!ready || resp_valid))
    else $error("ready rose without resp_valid");

endmodule

bind read_cache cache_test_assert assert_i (
  .clk        (clk),
  .rst        (rst),
  .ready      (ready),
  .resp_valid (resp_valid),
  .mem_rd     (mem_rd)
);

/* source/cache_test_top.sv */
// cache subsystem top: generator, cache, memory model, checker
`timescale 1ns/100ps

module cache_test_top
  import cache_addr_pkg::*, cache_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         mem_stall,
  output logic         req_valid,
  output byte_addr_t   req_addr,
  output logic         resp_valid,
  output byte_t        resp_data,
  output event_count_t hit_count,
  output event_count_t miss_count,
  output logic         test_ended,
  output logic         test_error
);

  logic       ready;
  logic       mem_rd;
  word_addr_t mem_addr;
  logic       mem_valid;
  word_t      mem_data;

  req_gen gen_i (
    .clk       (clk),
    .rst       (rst),
    .ready     (ready),
    .req_valid (req_valid),
    .req_addr  (req_addr)
  );

  read_cache cache_i (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_addr   (req_addr),
    .ready      (ready),
    .resp_valid (resp_valid),
    .resp_data  (resp_data),
    .mem_rd     (mem_rd),
    .mem_addr   (mem_addr),
    .mem_valid  (mem_valid),
    .mem_data   (mem_data),
    .hit_count  (hit_count),
    .miss_count (miss_count)
  );

  pattern_mem mem_i (
    .clk       (clk),
    .rst       (rst),
    .mem_rd    (mem_rd),
    .mem_addr  (mem_addr),
    .mem_stall (mem_stall),
    .mem_valid (mem_valid),
    .mem_data  (mem_data)
  );

  resp_check check_i (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .ready      (ready),
    .req_addr   (req_addr),
    .resp_valid (resp_valid),
    .resp_data  (resp_data),
    .test_ended (test_ended),
    .test_error (test_error)
  );

endmodule

/* source/resp_check.sv */
// response checker, compares bytes with the address pattern
// counts responses and flags the end of the test
`timescale 1ns/100ps
`include "cache_macros.svh"

module resp_check
  import cache_addr_pkg::*, cache_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       req_valid,
  input  logic       ready,
  input  byte_addr_t req_addr,
  input  logic       resp_valid,
  input  byte_t      resp_data,
  output logic       test_ended,
  output logic       test_error
);

  word_addr_t  chk_addr;
  byte_offs_t  chk_offs;
  word_t       expect_word;
  byte_t       expect_byte;
  test_count_t test_count;

  // address of the request in flight
  always_ff @(posedge clk) begin
    if (req_valid && ready) begin
      chk_addr <= req_addr[15:2];
      chk_offs <= req_addr[1:0];
    end
  end

  assign expect_word = { ~chk_addr[1:0], chk_addr[5:2], 2'b00, ~chk_addr[9:6], chk_addr[13:10],
                         chk_addr[9:6], 2'b11, ~chk_addr[13:10], chk_addr[1:0], ~chk_addr[5:2] };

  always_comb begin
    case (chk_offs)
      2'd0:    expect_byte = expect_word[31:24];
      2'd1:    expect_byte = expect_word[23:16];
      2'd2:    expect_byte = expect_word[15:8];
      default: expect_byte = expect_word[7:0];
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      test_count <= '0;
      test_ended <= 1'b0;
      test_error <= 1'b0;
    end else if (test_count != `NUM_TESTS) begin
      if (resp_valid) begin
        test_count <= test_count + 20'd1;
        // error sticks until reset
        if (resp_data != expect_byte) begin
          test_error <= 1'b1;
        end
      end
    end else begin
      test_ended <= 1'b1;
    end
  end

endmodule

/* source/pattern_mem.sv */
// backing memory model with stretchable latency
// answers each read with the address pattern word
`timescale 1ns/100ps
`include "cache_macros.svh"

module pattern_mem
  import cache_addr_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       mem_rd,
  input  word_addr_t mem_addr,
  input  logic       mem_stall,
  output logic       mem_valid,
  output word_t      mem_data
);

  word_addr_t rd_addr;
  logic       busy;
  logic [3:0] lat_count;
  logic       done;

  // last countdown step, skipped in stalled cycles
  assign done = busy & ~mem_stall & (lat_count == 4'd1);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy      <= 1'b0;
      lat_count <= 4'd0;
      mem_valid <= 1'b0;
    end else begin
      mem_valid <= done;
      if (mem_rd) begin
        busy      <= 1'b1;
        lat_count <= 4'(`MEM_LATENCY - 1);
      end else if (done) begin
        busy <= 1'b0;
      end else if (busy && !mem_stall) begin
        lat_count <= lat_count - 4'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (mem_rd) begin
      rd_addr <= mem_addr;
    end
    if (done) begin
      mem_data <= { ~rd_addr[1:0], rd_addr[5:2], 2'b00, ~rd_addr[9:6], rd_addr[13:10],
                    rd_addr[9:6], 2'b11, ~rd_addr[13:10], rd_addr[1:0], ~rd_addr[5:2] };
    end
  end

endmodule

/* source/read_cache.sv */
// blocking two-way set-associative read cache
// one word per line, one LRU bit per set, hit and miss counters
`timescale 1ns/100ps
`include "cache_macros.svh"

module read_cache
  import cache_addr_pkg::*, cache_ctrl_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         req_valid,
  input  byte_addr_t   req_addr,
  output logic         ready,
  output logic         resp_valid,
  output byte_t        resp_data,
  output logic         mem_rd,
  output word_addr_t   mem_addr,
  input  logic         mem_valid,
  input  word_t        mem_data,
  output event_count_t hit_count,
  output event_count_t miss_count
);

  cache_tag_t tag_w0 [`CACHE_SETS];
  cache_tag_t tag_w1 [`CACHE_SETS];
  word_t      data_w0 [`CACHE_SETS];
  word_t      data_w1 [`CACHE_SETS];
  logic [`CACHE_SETS-1:0] valid_w0;
  logic [`CACHE_SETS-1:0] valid_w1;
  // lru names the way to replace next
  logic [`CACHE_SETS-1:0] lru;

  cache_state_t state;
  set_index_t   req_idx;
  cache_tag_t   req_tag;
  logic         take;
  logic         hit_w0;
  logic         hit_w1;
  word_t        hit_data;
  // request under fill
  set_index_t   fill_idx;
  cache_tag_t   fill_tag;
  byte_offs_t   fill_offs;
  logic         fill_way;
  word_t        fill_data;

  function automatic byte_t pick_byte(word_t w, byte_offs_t offs);
    case (offs)
      2'd0:    return w[31:24];
      2'd1:    return w[23:16];
      2'd2:    return w[15:8];
      default: return w[7:0];
    endcase
  endfunction

  // ------------------------------
  // tag lookup
  // ------------------------------

  assign req_idx  = req_addr[7:2];
  assign req_tag  = req_addr[15:8];
  assign ready    = (state == st_lookup);
  assign take     = req_valid & ready;
  assign hit_w0   = valid_w0[req_idx] && (tag_w0[req_idx] == req_tag);
  assign hit_w1   = valid_w1[req_idx] && (tag_w1[req_idx] == req_tag);
  assign hit_data = hit_w0 ? data_w0[req_idx] : data_w1[req_idx];

  // ------------------------------
  // control
  // ------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= st_lookup;
      valid_w0   <= '0;
      valid_w1   <= '0;
      lru        <= '0;
      resp_valid <= 1'b0;
      mem_rd     <= 1'b0;
      hit_count  <= '0;
      miss_count <= '0;
    end else begin
      resp_valid <= 1'b0;
      mem_rd     <= 1'b0;
      case (state)
        st_lookup: begin
          if (take && (hit_w0 || hit_w1)) begin
            resp_valid   <= 1'b1;
            lru[req_idx] <= hit_w0;
            hit_count    <= hit_count + 16'd1;
          end else if (take) begin
            state      <= st_fill;
            mem_rd     <= 1'b1;
            miss_count <= miss_count + 16'd1;
          end
        end
        st_fill: begin
          if (mem_valid) begin
            state <= st_reply;
          end
        end
        default: begin
          // line written here, answer leaves next cycle
          if (fill_way) begin
            valid_w1[fill_idx] <= 1'b1;
          end else begin
            valid_w0[fill_idx] <= 1'b1;
          end
          lru[fill_idx] <= ~fill_way;
          resp_valid    <= 1'b1;
          state         <= st_lookup;
        end
      endcase
    end
  end

  // ------------------------------
  // arrays and payload
  // ------------------------------

  always_ff @(posedge clk) begin
    if (take) begin
      fill_idx  <= req_idx;
      fill_tag  <= req_tag;
      fill_offs <= req_addr[1:0];
      fill_way  <= lru[req_idx];
      mem_addr  <= req_addr[15:2];
      resp_data <= pick_byte(hit_data, req_addr[1:0]);
    end
    if (state == st_fill && mem_valid) begin
      fill_data <= mem_data;
    end
    if (state == st_reply) begin
      resp_data <= pick_byte(fill_data, fill_offs);
      if (fill_way) begin
        tag_w1[fill_idx]  <= fill_tag;
        data_w1[fill_idx] <= fill_data;
      end else begin
        tag_w0[fill_idx]  <= fill_tag;
        data_w0[fill_idx] <= fill_data;
      end
    end
  end

endmodule

/* source/req_gen.sv */
// paced read-request generator
// holdoff, request spacing and address jump table
`timescale 1ns/100ps
`include "cache_macros.svh"

module req_gen
  import cache_addr_pkg::*, cache_ctrl_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       ready,
  output logic       req_valid,
  output byte_addr_t req_addr
);

  logic [7:0]  holdoff;
  logic        holdoff_counting;
  logic [3:0]  distance;
  logic        distance_restart;
  logic        issue;
  test_count_t gen_state;
  logic        jump;
  byte_addr_t  target;

  // ------------------------------
  // pacing
  // ------------------------------

  assign holdoff_counting = (holdoff != 8'd0);
  assign distance_restart = (distance == `DISTANCE);
  assign issue = ready & distance_restart & ~holdoff_counting;

  always_ff @(posedge clk) begin
    if (rst) begin
      holdoff <= `HOLDOFF;
    end else if (holdoff_counting) begin
      holdoff <= holdoff - 8'd1;
    end
  end

  // distance only advances while the cache can take a request
  always_ff @(posedge clk) begin
    if (rst || holdoff_counting) begin
      distance <= 4'd0;
    end else if (ready) begin
      distance <= distance_restart ? 4'd0 : distance + 4'd1;
    end
  end

  // ------------------------------
  // address stream
  // ------------------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      req_valid <= 1'b0;
      req_addr  <= 16'hFFFF;
      gen_state <= '0;
      jump      <= 1'b0;
    end else if (ready) begin
      req_valid <= distance_restart & ~holdoff_counting;
      if (issue) begin
        gen_state <= gen_state + 20'd1;
        req_addr  <= jump ? target : req_addr + 16'h0001;
        case (gen_state)
          20'h0003F, 20'h0007F, 20'h000BF, 20'h000FF,
          20'h0013F, 20'h0017F, 20'h001BF, 20'h001FF: jump <= 1'b1;
          default: jump <= 1'b0;
        endcase
      end
    end
  end

  // jump target, only looked at when jump is set
  always_ff @(posedge clk) begin
    if (issue) begin
      case (gen_state)
        20'h000FF, 20'h0013F, 20'h0017F, 20'h001BF: target <= 16'h8000;
        default: target <= 16'h0000;
      endcase
    end
  end

endmodule

/* source/cache_ctrl_pkg.sv */
// control types: cache state machine and counters
package cache_ctrl_pkg;

  // lookup accepts requests, fill waits for memory,
  // reply writes the line and answers
  typedef enum logic [1:0] {
    st_lookup,
    st_fill,
    st_reply
  } cache_state_t;

  // request and response numbers
  typedef logic [19:0] test_count_t;

  // hit and miss statistics
  typedef logic [15:0] event_count_t;

endpackage

/* source/cache_addr_pkg.sv */
// address and data types of the cache subsystem
package cache_addr_pkg;

  // byte address as issued by the generator
  typedef logic [15:0] byte_addr_t;

  // word address, byte address without offset
  typedef logic [13:0] word_addr_t;

  // low word address bits select the set
  typedef logic [5:0] set_index_t;

  // remaining high word address bits
  typedef logic [7:0] cache_tag_t;

  typedef logic [31:0] word_t;
  typedef logic [7:0] byte_t;

  // byte within a word, 0 is the most significant byte
  typedef logic [1:0] byte_offs_t;

endpackage

/* source/cache_macros.svh */
// test parameters shared by generator, checker, cache and memory
// sizes and latencies of the cache subsystem
`ifndef CACHE_MACROS_SVH
`define CACHE_MACROS_SVH

// idle cycles before the first request (up to 255)
`define HOLDOFF 8'd80

// extra ready cycles between two requests (0..15)
`define DISTANCE 4'd6

// number of responses the checker waits for
`define NUM_TESTS 20'd1000

// ------------------------------
// cache and memory geometry
// ------------------------------

// sets in the two-way cache, one word per line
`define CACHE_SETS 64

// base cycles from mem_rd to mem_valid, at least 2
`define MEM_LATENCY 4

`endif
